/* list.f */
+incdir+sim
design/vlane_op_pkg.sv
design/vlane_res_pkg.sv
design/lane_issue.sv
design/arith_unit.sv
design/mul_unit.sv
design/div_unit.sv
design/lane_writeback.sv
design/vector_lane.sv
sim/tb_vector_lane.sv

/* Bender.yml */
package:
  name: vector_lane

sources:
  - files:
      - design/vlane_op_pkg.sv
      - design/vlane_res_pkg.sv
      - design/lane_issue.sv
      - design/arith_unit.sv
      - design/mul_unit.sv
      - design/div_unit.sv
      - design/lane_writeback.sv
      - design/vector_lane.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_vector_lane.sv

/* sim/tb_checks.svh */
// Vector lane testbench compare tasks and error counters
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errors = 0;  // Wrong data, tag, exc or flag level
int other_errors = 0;  // Missing or extra results, timeout

// Whole result word, data tag and exception
task automatic check_result(input string name, input vlane_res_pkg::lane_result_t exp,
                            input vlane_res_pkg::lane_result_t act);
  if (act !== exp) begin
    value_errors++;
    $display("CHECK FAILED %s: expected data=%h tag=%h exc=%s, actual data=%h tag=%h exc=%s",
             name, exp.data, exp.tag, exp.exc.name(), act.data, act.tag, act.exc.name());
  end
endtask

// Single-bit status, busy or issue_reject
task automatic check_flag(input string name, input string what, input logic exp,
                          input logic act);
  if (act !== exp) begin
    value_errors++;
    $display("CHECK FAILED %s: %s expected %b, actual %b", name, what, exp, act);
  end
endtask

task automatic report_protocol_error(input string name, input string msg);
  other_errors++;
  $display("ERROR %s: %s", name, msg);
endtask

task automatic print_counts();
  $display("Errors: %0d value mismatches, %0d protocol errors", value_errors, other_errors);
endtask

`endif

/* sim/tb_vector_lane.sv */
// Vector lane testbench with directed tests checked against a reference model
module tb_vector_lane;

  localparam int MUL_STAGES = 3;
  localparam int DIV_LAT    = 34;    // op_valid edge to result edge
  localparam int MAX_CYCLES = 2000;  // All tests plus margin

  logic                           CLK;
  logic                           rst_n;
  logic                           op_valid;
  vlane_op_pkg::lane_op_t         op;
  logic                           result_valid;
  vlane_res_pkg::lane_result_t    result;
  logic                           busy;
  logic                           issue_reject;

  int                             cycle;      // Posedges since start
  string                          test_name;
  int                             exp_due[$]; // Cycle each result should show
  vlane_res_pkg::lane_result_t    exp_res[$];
  int                             busy_from;  // First and last expected busy cycle
  int                             busy_to;
  logic [vlane_op_pkg::TAG_W-1:0] next_tag;

  `include "tb_checks.svh"

  vector_lane #(.MUL_STAGES(MUL_STAGES)) dut (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .op_valid     (op_valid),
    .op           (op),
    .result_valid (result_valid),
    .result       (result),
    .busy         (busy),
    .issue_reject (issue_reject)
  );

  always #2 CLK = ~CLK;

  always @(posedge CLK) cycle <= cycle + 1;

  // Legal divide ops take the long path and raise busy
  function automatic logic is_div(vlane_op_pkg::lane_op_t o);
    return (o.fu_type == vlane_op_pkg::FU_DIV) &&
           (o.opcode inside {vlane_op_pkg::OP_DIV, vlane_op_pkg::OP_DIVU,
                             vlane_op_pkg::OP_REM, vlane_op_pkg::OP_REMU});
  endfunction

  function automatic vlane_res_pkg::lane_result_t model_div(vlane_op_pkg::lane_op_t o);
    vlane_res_pkg::lane_result_t r;
    logic signed [31:0]          sa, sb;
    logic                        sgn, rem;
    sa    = o.vs1;
    sb    = o.vs2;
    sgn   = (o.opcode == vlane_op_pkg::OP_DIV) || (o.opcode == vlane_op_pkg::OP_REM);
    rem   = (o.opcode == vlane_op_pkg::OP_REM) || (o.opcode == vlane_op_pkg::OP_REMU);
    r.tag = o.tag;
    r.exc = vlane_res_pkg::NONE;
    if (o.vs2 == 32'd0) begin
      r.exc  = vlane_res_pkg::DIV_ZERO;
      r.data = rem ? o.vs1 : 32'hFFFF_FFFF;  // Dividend back for a remainder
    end else if (sgn && o.vs1 == 32'h8000_0000 && o.vs2 == 32'hFFFF_FFFF) begin
      r.exc  = vlane_res_pkg::OVERFLOW;
      r.data = rem ? 32'd0 : 32'h8000_0000;
    end else if (sgn) begin
      if (rem) r.data = sa % sb;  // Truncates toward zero
      else     r.data = sa / sb;
    end else begin
      r.data = rem ? o.vs1 % o.vs2 : o.vs1 / o.vs2;
    end
    return r;
  endfunction

  // Expected result of any op under the lane rules
  function automatic vlane_res_pkg::lane_result_t model(vlane_op_pkg::lane_op_t o);
    vlane_res_pkg::lane_result_t r;
    logic signed [31:0]          sa, sb;
    logic [63:0]                 sp, up;
    sa     = o.vs1;
    sb     = o.vs2;
    sp     = {{32{o.vs1[31]}}, o.vs1} * {{32{o.vs2[31]}}, o.vs2};  // Low 64 bits signed
    up     = {32'd0, o.vs1} * {32'd0, o.vs2};
    r.tag  = o.tag;
    r.exc  = vlane_res_pkg::NONE;
    r.data = 32'd0;
    case (o.fu_type)
      vlane_op_pkg::FU_ARITH: begin
        case (o.opcode)
          vlane_op_pkg::OP_ADD:  r.data = o.vs1 + o.vs2;
          vlane_op_pkg::OP_SUB:  r.data = o.vs1 - o.vs2;
          vlane_op_pkg::OP_AND:  r.data = o.vs1 & o.vs2;
          vlane_op_pkg::OP_OR:   r.data = o.vs1 | o.vs2;
          vlane_op_pkg::OP_XOR:  r.data = o.vs1 ^ o.vs2;
          vlane_op_pkg::OP_SLL:  r.data = o.vs1 << o.vs2[4:0];
          vlane_op_pkg::OP_SRL:  r.data = o.vs1 >> o.vs2[4:0];
          vlane_op_pkg::OP_SRA:  r.data = sa >>> o.vs2[4:0];
          vlane_op_pkg::OP_MIN:  r.data = (sa < sb) ? o.vs1 : o.vs2;
          vlane_op_pkg::OP_MAX:  r.data = (sa > sb) ? o.vs1 : o.vs2;
          vlane_op_pkg::OP_ANDN: r.data = o.vs1 & ~o.vs2;
          default:               r.exc  = vlane_res_pkg::UNSUPPORTED;
        endcase
      end
      vlane_op_pkg::FU_MUL: begin
        case (o.opcode)
          vlane_op_pkg::OP_MUL:   r.data = sp[31:0];
          vlane_op_pkg::OP_MULH:  r.data = sp[63:32];
          vlane_op_pkg::OP_MULHU: r.data = up[63:32];
          default:                r.exc  = vlane_res_pkg::UNSUPPORTED;
        endcase
      end
      vlane_op_pkg::FU_DIV: begin
        if (is_div(o)) r = model_div(o);
        else           r.exc = vlane_res_pkg::UNSUPPORTED;
      end
      default: r.exc = vlane_res_pkg::UNSUPPORTED;  // PERM, load/store
    endcase
    return r;
  endfunction

  function automatic vlane_op_pkg::vl_opcode_e rand_arith_op();
    vlane_op_pkg::vl_opcode_e ops [11];
    ops = '{vlane_op_pkg::OP_ADD, vlane_op_pkg::OP_SUB, vlane_op_pkg::OP_AND,
            vlane_op_pkg::OP_OR, vlane_op_pkg::OP_XOR, vlane_op_pkg::OP_SLL,
            vlane_op_pkg::OP_SRL, vlane_op_pkg::OP_SRA, vlane_op_pkg::OP_MIN,
            vlane_op_pkg::OP_MAX, vlane_op_pkg::OP_ANDN};
    return ops[$urandom_range(0, 10)];
  endfunction

  // Drive one op on the next edge and book its result
  task automatic issue(input vlane_op_pkg::fu_type_e fu, input vlane_op_pkg::vl_opcode_e opc,
                       input logic [31:0] a, input logic [31:0] b);
    vlane_op_pkg::lane_op_t o;
    int                     c;
    logic                   rej;
    o        = '{fu_type: fu, opcode: opc, vs1: a, vs2: b, tag: next_tag};
    next_tag = next_tag + 1'b1;
    @(posedge CLK);
    c        = cycle;
    rej      = (c + 1 >= busy_from) && (c + 1 <= busy_to);  // Busy while op_valid is up
    op_valid <= 1'b1;
    op       <= o;
    if (!rej) begin
      exp_due.push_back(c + 2 + (is_div(o) ? DIV_LAT : MUL_STAGES + 2));
      exp_res.push_back(model(o));
      if (is_div(o)) begin
        busy_from = c + 2;
        busy_to   = c + 1 + DIV_LAT;  // Low again in the result cycle
      end
    end
    @(negedge CLK);
    check_flag(test_name, "issue_reject", rej, issue_reject);
  endtask

  task automatic stop_issue();
    @(posedge CLK);
    op_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_due.size() != 0) @(posedge CLK);
  endtask

  task automatic one_div(input vlane_op_pkg::vl_opcode_e opc, input logic [31:0] a,
                         input logic [31:0] b);
    issue(vlane_op_pkg::FU_DIV, opc, a, b);
    stop_issue();
    wait_drain();
  endtask

  // Result port and busy level sampled mid-cycle
  always @(negedge CLK) begin
    if (rst_n) begin
      if (exp_due.size() != 0 && exp_due[0] == cycle) begin
        if (!result_valid) begin
          report_protocol_error(test_name, $sformatf("no result_valid at cycle %0d for tag %0h",
                                                     cycle, exp_res[0].tag));
        end else begin
          check_result(test_name, exp_res[0], result);
        end
        exp_due.delete(0);
        exp_res.delete(0);
      end else if (result_valid) begin
        report_protocol_error(test_name, $sformatf("result_valid with no op due at cycle %0d",
                                                   cycle));
      end
      check_flag(test_name, "busy", (cycle >= busy_from) && (cycle <= busy_to), busy);
    end
  end

  task automatic arith_back_to_back();
    test_name = "arith";
    for (int i = 0; i < 40; i++) begin
      issue(vlane_op_pkg::FU_ARITH, rand_arith_op(), $urandom(), $urandom());  // Back to back
    end
    stop_issue();
    wait_drain();
  endtask

  task automatic mul_with_arith();
    logic [31:0]              edge_val [4];
    vlane_op_pkg::vl_opcode_e mul_op [3];
    edge_val  = '{32'hFFFF_FFFF, 32'h8000_0000, 32'h0, 32'h7FFF_FFFF};
    mul_op    = '{vlane_op_pkg::OP_MUL, vlane_op_pkg::OP_MULH, vlane_op_pkg::OP_MULHU};
    test_name = "mul";
    for (int i = 0; i < 24; i++) begin
      // Edge value pairs first and random operands after
      issue(vlane_op_pkg::FU_MUL, mul_op[i % 3], (i < 12) ? edge_val[i % 4] : $urandom(),
            (i < 12) ? edge_val[(i / 4 + i) % 4] : $urandom());
      if (i % 2) issue(vlane_op_pkg::FU_ARITH, rand_arith_op(), $urandom(), $urandom());
    end
    stop_issue();
    wait_drain();
  endtask

  task automatic div_random();
    logic [31:0]              b;
    vlane_op_pkg::vl_opcode_e div_op [4];
    div_op    = '{vlane_op_pkg::OP_DIV, vlane_op_pkg::OP_DIVU,
                  vlane_op_pkg::OP_REM, vlane_op_pkg::OP_REMU};
    test_name = "div";
    for (int i = 0; i < 8; i++) begin
      b = $urandom() >> $urandom_range(0, 28);  // Spread of divisor sizes
      if (b == 32'd0) b = 32'd3;
      one_div(div_op[i % 4], $urandom(), b);
    end
  endtask

  task automatic div_corner_cases();
    test_name = "div_corner";
    one_div(vlane_op_pkg::OP_DIV, 32'h1234_5678, 32'd0);
    one_div(vlane_op_pkg::OP_DIVU, 32'hFFFF_0000, 32'd0);
    one_div(vlane_op_pkg::OP_REM, 32'h8000_0001, 32'd0);
    one_div(vlane_op_pkg::OP_REMU, 32'h0000_00FF, 32'd0);
    one_div(vlane_op_pkg::OP_DIV, 32'h8000_0000, 32'hFFFF_FFFF);  // Signed overflow
    one_div(vlane_op_pkg::OP_REM, 32'h8000_0000, 32'hFFFF_FFFF);
    one_div(vlane_op_pkg::OP_DIVU, 32'h8000_0000, 32'hFFFF_FFFF);  // Plain unsigned
  endtask

  task automatic busy_rejection();
    test_name = "reject";
    issue(vlane_op_pkg::FU_DIV, vlane_op_pkg::OP_DIVU, 32'd1000, 32'd7);
    stop_issue();
    repeat (3) @(posedge CLK);
    issue(vlane_op_pkg::FU_ARITH, vlane_op_pkg::OP_ADD, 32'd1, 32'd2);  // Dropped
    issue(vlane_op_pkg::FU_DIV, vlane_op_pkg::OP_DIV, 32'd100, 32'd5);   // Dropped
    stop_issue();
    wait_drain();
    issue(vlane_op_pkg::FU_ARITH, vlane_op_pkg::OP_XOR, 32'hA5A5_A5A5, 32'h0F0F_0F0F);
    issue(vlane_op_pkg::FU_DIV, vlane_op_pkg::OP_REM, 32'hFFFF_FFF9, 32'd2);
    stop_issue();
    wait_drain();
  endtask

  task automatic unsupported_ops();
    test_name = "unsupported";
    issue(vlane_op_pkg::FU_PERM, vlane_op_pkg::OP_ADD, $urandom(), $urandom());
    issue(vlane_op_pkg::FU_LOAD_STORE, vlane_op_pkg::OP_MUL, $urandom(), $urandom());
    issue(vlane_op_pkg::FU_MUL, vlane_op_pkg::OP_ADD, $urandom(), $urandom());
    issue(vlane_op_pkg::FU_ARITH, vlane_op_pkg::OP_SUB, $urandom(), $urandom());  // Legal
    issue(vlane_op_pkg::FU_DIV, vlane_op_pkg::OP_MULH, $urandom(), $urandom());
    stop_issue();
    wait_drain();
  endtask

  initial begin
    CLK       = 1'b0;
    rst_n     = 1'b0;
    op_valid  = 1'b0;
    op        = '0;
    cycle     = 0;
    next_tag  = '0;
    busy_from = 1;  // Empty window
    busy_to   = 0;
    test_name = "reset";
    void'($urandom(32'hdc40e64f));
    repeat (2) @(posedge CLK);
    rst_n <= 1'b1;
    @(negedge CLK);
    check_flag(test_name, "result_valid", 1'b0, result_valid);
    arith_back_to_back();
    mul_with_arith();
    div_random();
    div_corner_cases();
    busy_rejection();
    unsupported_ops();
    print_counts();
    if (value_errors + other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (cycle >= MAX_CYCLES);
    report_protocol_error(test_name, $sformatf("timeout after %0d cycles", MAX_CYCLES));
    print_counts();
    $display("Simulation failed");
    $finish;
  end

endmodule

/* design/vector_lane.sv */
// Vector lane top: issue, arith/mul/div units and result writeback
module vector_lane #(
  parameter int MUL_STAGES = 3  // 1 to 8
) (
  input  logic                        CLK,
  input  logic                        rst_n,
  input  logic                        op_valid,
  input  vlane_op_pkg::lane_op_t      op,
  output logic                        result_valid,
  output vlane_res_pkg::lane_result_t result,
  output logic                        busy,
  output logic                        issue_reject
);

  vlane_op_pkg::lane_op_t      issued;
  logic                        start_arith, start_mul, start_div;
  logic                        arith_valid, mul_valid, div_valid;
  vlane_res_pkg::lane_result_t arith_res, mul_res, div_res;

  lane_issue u_issue (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .op_valid     (op_valid),
    .op           (op),
    .div_busy     (busy),
    .issued       (issued),
    .start_arith  (start_arith),
    .start_mul    (start_mul),
    .start_div    (start_div),
    .issue_reject (issue_reject)
  );

  arith_unit #(.MUL_STAGES(MUL_STAGES)) u_arith (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .start_arith (start_arith),
    .issued      (issued),
    .arith_valid (arith_valid),
    .arith_res   (arith_res)
  );

  mul_unit #(.MUL_STAGES(MUL_STAGES)) u_mul (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .start_mul (start_mul),
    .issued    (issued),
    .mul_valid (mul_valid),
    .mul_res   (mul_res)
  );

  div_unit u_div (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .start_div (start_div),
    .issued    (issued),
    .div_valid (div_valid),
    .div_res   (div_res),
    .div_busy  (busy)       // Lane busy is the divider busy
  );

  lane_writeback u_wb (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .arith_valid  (arith_valid),
    .mul_valid    (mul_valid),
    .div_valid    (div_valid),
    .arith_res    (arith_res),
    .mul_res      (mul_res),
    .div_res      (div_res),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

/* design/lane_writeback.sv */
// Lane writeback: merges the three unit results onto one registered port
module lane_writeback (
  input  logic                        CLK,
  input  logic                        rst_n,
  input  logic                        arith_valid,
  input  logic                        mul_valid,
  input  logic                        div_valid,
  input  vlane_res_pkg::lane_result_t arith_res,
  input  vlane_res_pkg::lane_result_t mul_res,
  input  vlane_res_pkg::lane_result_t div_res,
  output logic                        result_valid,
  output vlane_res_pkg::lane_result_t result
);

  localparam int RES_W = $bits(vlane_res_pkg::lane_result_t);

  logic             any_valid;
  logic [RES_W-1:0] merged;

  assign any_valid = arith_valid | mul_valid | div_valid;

  // One-hot AND-OR, units never overlap
  assign merged = ({RES_W{arith_valid}} & arith_res)
                | ({RES_W{mul_valid}}   & mul_res)
                | ({RES_W{div_valid}}   & div_res);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) result_valid <= 1'b0;
    else        result_valid <= any_valid;
  end

  // Last result held while idle
  always_ff @(posedge CLK) begin
    if (any_valid) result <= vlane_res_pkg::lane_result_t'(merged);
  end

endmodule

/* design/div_unit.sv */
// Iterative radix-2 divider for DIV, DIVU, REM and REMU with RISC-V corner cases
module div_unit (
  input  logic                       CLK,
  input  logic                       rst_n,
  input  logic                       start_div,
  input  vlane_op_pkg::lane_op_t     issued,
  output logic                       div_valid,
  output vlane_res_pkg::lane_result_t div_res,
  output logic                       div_busy
);

  typedef enum logic [1:0] {IDLE, RUN, DONE} div_state_e;

  div_state_e                     state;
  logic [4:0]                     cnt;      // Iteration index
  logic [31:0]                    quo_q;    // Dividend shifts out, quotient shifts in
  logic [31:0]                    rem_q;
  logic [31:0]                    dvs_q;    // Divisor magnitude
  logic [31:0]                    dvd_q;    // Original dividend for rem by zero
  logic [vlane_op_pkg::TAG_W-1:0] tag_q;
  logic                           is_rem, neg_q, neg_r, zero_q, ovf_q;
  logic                           sgn, a_neg, b_neg;
  logic [32:0]                    shifted, diff;
  logic [31:0]                    q_fix, r_fix;

  assign sgn   = (issued.opcode == vlane_op_pkg::OP_DIV) | (issued.opcode == vlane_op_pkg::OP_REM);
  assign a_neg = sgn & issued.vs1[31];
  assign b_neg = sgn & issued.vs2[31];

  // One shift-subtract step
  assign shifted = {rem_q, quo_q[31]};
  assign diff    = shifted - {1'b0, dvs_q};

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: if (start_div) begin
          state <= RUN;
          cnt   <= '0;
        end
        RUN: begin
          cnt <= cnt + 5'd1;
          if (cnt == 5'd31) state <= DONE;  // 32nd step
        end
        DONE:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == IDLE && start_div) begin
      quo_q  <= a_neg ? -issued.vs1 : issued.vs1;
      rem_q  <= '0;
      dvs_q  <= b_neg ? -issued.vs2 : issued.vs2;
      dvd_q  <= issued.vs1;
      tag_q  <= issued.tag;
      is_rem <= (issued.opcode == vlane_op_pkg::OP_REM) | (issued.opcode == vlane_op_pkg::OP_REMU);
      neg_q  <= a_neg ^ b_neg;
      neg_r  <= a_neg;  // Remainder follows dividend sign
      zero_q <= (issued.vs2 == '0);
      ovf_q  <= sgn & (issued.vs1 == 32'h8000_0000) & (issued.vs2 == 32'hFFFF_FFFF);
    end else if (state == RUN) begin
      if (!diff[32]) begin
        rem_q <= diff[31:0];
        quo_q <= {quo_q[30:0], 1'b1};
      end else begin
        rem_q <= shifted[31:0];
        quo_q <= {quo_q[30:0], 1'b0};
      end
    end
  end

  // Sign fix on the way out
  assign q_fix = neg_q ? -quo_q : quo_q;  // Overflow case lands on 0x8000_0000 here
  assign r_fix = neg_r ? -rem_q : rem_q;

  always_comb begin
    div_res.tag = tag_q;
    if (zero_q) begin
      div_res.data = is_rem ? dvd_q : 32'hFFFF_FFFF;
      div_res.exc  = vlane_res_pkg::DIV_ZERO;
    end else begin
      div_res.data = is_rem ? r_fix : q_fix;
      div_res.exc  = ovf_q ? vlane_res_pkg::OVERFLOW : vlane_res_pkg::NONE;
    end
  end

  assign div_valid = (state == DONE);
  assign div_busy  = start_div | (state != IDLE);  // Covers the start cycle too

endmodule

/* design/mul_unit.sv */
// Pipelined 32x32 multiplier returning the low or high product word
module mul_unit #(
  parameter int MUL_STAGES = 3
) (
  input  logic                       CLK,
  input  logic                       rst_n,
  input  logic                       start_mul,
  input  vlane_op_pkg::lane_op_t     issued,
  output logic                       mul_valid,
  output vlane_res_pkg::lane_result_t mul_res
);

  typedef struct packed {
    logic                           hi;   // Return upper word
    logic [vlane_op_pkg::TAG_W-1:0] tag;
    logic [63:0]                    prod;
  } mul_stage_t;

  logic                           op_vld;
  logic signed [32:0]             op_a, op_b;  // Sign or zero extended
  logic                           op_hi;
  logic [vlane_op_pkg::TAG_W-1:0] op_tag;
  logic signed [65:0]             full_prod;
  mul_stage_t                     stage [MUL_STAGES];
  logic [MUL_STAGES-1:0]          stage_vld;
  logic                           sgn;

  // Only MULHU is unsigned and the low word does not depend on sign
  assign sgn = (issued.opcode != vlane_op_pkg::OP_MULHU);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      op_vld    <= 1'b0;
      stage_vld <= '0;
    end else begin
      op_vld       <= start_mul;
      stage_vld[0] <= op_vld;
      for (int i = 1; i < MUL_STAGES; i++) begin
        stage_vld[i] <= stage_vld[i-1];
      end
    end
  end

  // Operand capture
  always_ff @(posedge CLK) begin
    if (start_mul) begin
      op_a   <= {sgn & issued.vs1[31], issued.vs1};
      op_b   <= {sgn & issued.vs2[31], issued.vs2};
      op_hi  <= (issued.opcode != vlane_op_pkg::OP_MUL);
      op_tag <= issued.tag;
    end
  end

  assign full_prod = op_a * op_b;

  // Product pipeline MUL_STAGES deep
  always_ff @(posedge CLK) begin
    stage[0] <= '{hi: op_hi, tag: op_tag, prod: full_prod[63:0]};
    for (int i = 1; i < MUL_STAGES; i++) begin
      stage[i] <= stage[i-1];
    end
  end

  assign mul_valid    = stage_vld[MUL_STAGES-1];
  assign mul_res.data = stage[MUL_STAGES-1].hi ? stage[MUL_STAGES-1].prod[63:32]
                                               : stage[MUL_STAGES-1].prod[31:0];
  assign mul_res.tag  = stage[MUL_STAGES-1].tag;
  assign mul_res.exc  = vlane_res_pkg::NONE;

endmodule

/* design/arith_unit.sv */
// Integer ALU and mask logic, delayed to match the multiplier latency
module arith_unit #(
  parameter int MUL_STAGES = 3
) (
  input  logic                       CLK,
  input  logic                       rst_n,
  input  logic                       start_arith,
  input  vlane_op_pkg::lane_op_t     issued,
  output logic                       arith_valid,
  output vlane_res_pkg::lane_result_t arith_res
);

  vlane_res_pkg::lane_result_t alu_res;
  vlane_res_pkg::lane_result_t pipe_res [MUL_STAGES+1];
  logic [MUL_STAGES:0]         pipe_vld;
  logic [31:0]                 a, b;
  logic [4:0]                  shamt;

  assign a     = issued.vs1;
  assign b     = issued.vs2;
  assign shamt = b[4:0];  // Low 5 bits only

  always_comb begin
    alu_res.tag  = issued.tag;
    alu_res.exc  = vlane_res_pkg::NONE;
    alu_res.data = '0;
    if (issued.fu_type != vlane_op_pkg::FU_ARITH) begin
      alu_res.exc = vlane_res_pkg::UNSUPPORTED;  // PERM, LS, misrouted opcodes
    end else begin
      case (issued.opcode)
        vlane_op_pkg::OP_ADD:  alu_res.data = a + b;
        vlane_op_pkg::OP_SUB:  alu_res.data = a - b;
        vlane_op_pkg::OP_AND:  alu_res.data = a & b;
        vlane_op_pkg::OP_OR:   alu_res.data = a | b;
        vlane_op_pkg::OP_XOR:  alu_res.data = a ^ b;
        vlane_op_pkg::OP_SLL:  alu_res.data = a << shamt;
        vlane_op_pkg::OP_SRL:  alu_res.data = a >> shamt;
        vlane_op_pkg::OP_SRA:  alu_res.data = $signed(a) >>> shamt;
        vlane_op_pkg::OP_MIN:  alu_res.data = ($signed(a) < $signed(b)) ? a : b;
        vlane_op_pkg::OP_MAX:  alu_res.data = ($signed(a) > $signed(b)) ? a : b;
        vlane_op_pkg::OP_ANDN: alu_res.data = a & ~b;
        default:               alu_res.exc  = vlane_res_pkg::UNSUPPORTED;
      endcase
    end
  end

  // Compute stage plus MUL_STAGES delay slots
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) pipe_vld <= '0;
    else        pipe_vld <= {pipe_vld[MUL_STAGES-1:0], start_arith};
  end

  always_ff @(posedge CLK) begin
    pipe_res[0] <= alu_res;
    for (int i = 1; i <= MUL_STAGES; i++) begin
      pipe_res[i] <= pipe_res[i-1];
    end
  end

  assign arith_valid = pipe_vld[MUL_STAGES];
  assign arith_res   = pipe_res[MUL_STAGES];

endmodule

/* design/lane_issue.sv */
// Lane issue stage: input register, class/opcode decode and busy rejection
module lane_issue (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  logic                   op_valid,
  input  vlane_op_pkg::lane_op_t op,
  input  logic                   div_busy,
  output vlane_op_pkg::lane_op_t issued,
  output logic                   start_arith,
  output logic                   start_mul,
  output logic                   start_div,
  output logic                   issue_reject
);

  logic accept;
  logic legal;
  logic mul_d, div_d;

  // Validity table, class against opcode
  function automatic logic op_legal(vlane_op_pkg::fu_type_e fu, vlane_op_pkg::vl_opcode_e opc);
    logic ok;
    ok = 1'b0;
    case (fu)
      vlane_op_pkg::FU_ARITH:
        ok = (opc inside {vlane_op_pkg::OP_ADD, vlane_op_pkg::OP_SUB, vlane_op_pkg::OP_AND,
                          vlane_op_pkg::OP_OR, vlane_op_pkg::OP_XOR, vlane_op_pkg::OP_SLL,
                          vlane_op_pkg::OP_SRL, vlane_op_pkg::OP_SRA, vlane_op_pkg::OP_MIN,
                          vlane_op_pkg::OP_MAX, vlane_op_pkg::OP_ANDN});
      vlane_op_pkg::FU_MUL:
        ok = (opc inside {vlane_op_pkg::OP_MUL, vlane_op_pkg::OP_MULH, vlane_op_pkg::OP_MULHU});
      vlane_op_pkg::FU_DIV:
        ok = (opc inside {vlane_op_pkg::OP_DIV, vlane_op_pkg::OP_DIVU,
                          vlane_op_pkg::OP_REM, vlane_op_pkg::OP_REMU});
      default: ok = 1'b0;  // PERM, LOAD_STORE and unused codes
    endcase
    return ok;
  endfunction

  assign accept       = op_valid & ~div_busy;
  assign issue_reject = op_valid & div_busy;  // Same-cycle drop flag

  assign legal = op_legal(op.fu_type, op.opcode);
  assign mul_d = accept & legal & (op.fu_type == vlane_op_pkg::FU_MUL);
  assign div_d = accept & legal & (op.fu_type == vlane_op_pkg::FU_DIV);

  // Strobes, exactly one per accepted op
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      start_arith <= 1'b0;
      start_mul   <= 1'b0;
      start_div   <= 1'b0;
    end else begin
      start_arith <= accept & ~mul_d & ~div_d;  // Also catches unsupported ops
      start_mul   <= mul_d;
      start_div   <= div_d;
    end
  end

  // Operation payload
  always_ff @(posedge CLK) begin
    if (accept) issued <= op;
  end

endmodule

/* design/vlane_res_pkg.sv */
// Result-side types for one vector lane: exception codes and the result word
package vlane_res_pkg;

  // Per-element exception code
  typedef enum logic [1:0] {
    NONE        = 2'd0,
    DIV_ZERO    = 2'd1,
    OVERFLOW    = 2'd2,  // Signed -2^31 / -1
    UNSUPPORTED = 2'd3   // Class or opcode not handled by the lane
  } exc_e;

  // Result word returned by every functional unit
  typedef struct packed {
    logic [31:0]                    data;
    logic [vlane_op_pkg::TAG_W-1:0] tag;
    exc_e                           exc;
  } lane_result_t;

endpackage

/* design/vlane_op_pkg.sv */
// Operation-side types for one vector lane: classes, opcodes, issued operation
package vlane_op_pkg;

  localparam int TAG_W = 4;  // Tag width, carried through to the result

  // Functional unit class of an element operation
  typedef enum logic [2:0] {
    FU_ARITH      = 3'd0,
    FU_MUL        = 3'd1,
    FU_DIV        = 3'd2,
    FU_PERM       = 3'd3,  // Not implemented in this lane
    FU_LOAD_STORE = 3'd4   // Not implemented in this lane
  } fu_type_e;

  // Opcode within a class, grouped by class in the upper bits
  typedef enum logic [4:0] {
    OP_ADD   = 5'h00,
    OP_SUB   = 5'h01,
    OP_AND   = 5'h02,
    OP_OR    = 5'h03,
    OP_XOR   = 5'h04,
    OP_SLL   = 5'h05,
    OP_SRL   = 5'h06,
    OP_SRA   = 5'h07,
    OP_MIN   = 5'h08,  // Signed
    OP_MAX   = 5'h09,  // Signed
    OP_ANDN  = 5'h0A,  // Mask and-not, vs1 & ~vs2
    OP_MUL   = 5'h10,  // Low word
    OP_MULH  = 5'h11,  // High word, signed x signed
    OP_MULHU = 5'h12,  // High word, unsigned x unsigned
    OP_DIV   = 5'h18,
    OP_DIVU  = 5'h19,
    OP_REM   = 5'h1A,
    OP_REMU  = 5'h1B
  } vl_opcode_e;

  // One element operation as seen at the lane input
  typedef struct packed {
    fu_type_e           fu_type;
    vl_opcode_e         opcode;
    logic [31:0]        vs1;
    logic [31:0]        vs2;
    logic [TAG_W-1:0]   tag;
  } lane_op_t;

endpackage
